//--- hw/gpio_pkg.sv
//////////////////////////////////////////////////////////////////////
// shared constants for the APB GPIO block
// XLEN may be 32 or 64; register words are always 32 bits wide
// SYNC_STAGES must be at least 2 so edge detection has a stage pair
// LOOPBACK is a test aid only and must stay off in a real pad ring
//////////////////////////////////////////////////////////////////////

`default_nettype none

package gpio_pkg;

  // bus and pin geometry
  localparam int XLEN        = 32;
  localparam int NPINS       = 32;
  localparam int SYNC_STAGES = 3;

  // feed enabled outputs back into the input path
  localparam bit LOOPBACK = 1'b0;

  //////////////////////////////////////////////////////////////////////
  // register map, byte offsets in an 8-bit space
  //////////////////////////////////////////////////////////////////////
  localparam logic [7:0] ADDR_INPUT_VAL  = 8'h00;
  localparam logic [7:0] ADDR_INPUT_EN   = 8'h04;
  localparam logic [7:0] ADDR_OUTPUT_EN  = 8'h08;
  localparam logic [7:0] ADDR_OUTPUT_VAL = 8'h0C;
  localparam logic [7:0] ADDR_RISE_IE    = 8'h18;
  localparam logic [7:0] ADDR_RISE_IP    = 8'h1C;
  localparam logic [7:0] ADDR_FALL_IE    = 8'h20;
  localparam logic [7:0] ADDR_FALL_IP    = 8'h24;
  localparam logic [7:0] ADDR_HIGH_IE    = 8'h28;
  localparam logic [7:0] ADDR_HIGH_IP    = 8'h2C;
  localparam logic [7:0] ADDR_LOW_IE     = 8'h30;
  localparam logic [7:0] ADDR_LOW_IP     = 8'h34;
  localparam logic [7:0] ADDR_IOF_EN     = 8'h38;
  localparam logic [7:0] ADDR_IOF_SEL    = 8'h3C;
  localparam logic [7:0] ADDR_OUT_XOR    = 8'h40;

  // INPUT_VAL is read-only, so it has no write select bit
  localparam int NREGS = 14;

  // bit positions in the one-hot write select
  typedef enum logic [3:0] {
    REG_INPUT_EN, REG_OUTPUT_EN, REG_OUTPUT_VAL,
    REG_RISE_IE, REG_RISE_IP, REG_FALL_IE, REG_FALL_IP,
    REG_HIGH_IE, REG_HIGH_IP, REG_LOW_IE, REG_LOW_IP,
    REG_IOF_EN, REG_IOF_SEL, REG_OUT_XOR
  } reg_idx_e;

endpackage

`default_nettype wire

//--- hw/gpio_sync.sv
//////////////////////////////////////////////////////////////////////
// multi-stage pin synchronizer, reset to zero
// STAGES must be 2 or more; q_prev is the stage just before q
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module gpio_sync #(
  parameter int STAGES = gpio_pkg::SYNC_STAGES
) (
  input  logic                       PCLK,
  input  logic                       PRESETn,
  input  logic [gpio_pkg::NPINS-1:0] d,
  output logic [gpio_pkg::NPINS-1:0] q,
  output logic [gpio_pkg::NPINS-1:0] q_prev
);

  logic [gpio_pkg::NPINS-1:0] stage [STAGES];

  // shift chain, first stage samples the pins
  always_ff @(posedge PCLK or negedge PRESETn) begin
    if (!PRESETn) begin
      for (int i = 0; i < STAGES; i++) begin
        stage[i] <= '0;
      end
    end else begin
      stage[0] <= d;
      for (int i = 1; i < STAGES; i++) begin
        stage[i] <= stage[i-1];
      end
    end
  end

  // last stage is the settled value, previous one gives edges
  assign q      = stage[STAGES-1];
  assign q_prev = stage[STAGES-2];

endmodule

`default_nettype wire

//--- hw/gpio_apb_decode.sv
//////////////////////////////////////////////////////////////////////
// APB access decode for the GPIO block
// only naturally aligned 32-bit words are supported
// paddr[1:0] is ignored; for XLEN 64, paddr[2] picks the data half
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module gpio_apb_decode (
  input  logic                       PCLK,
  input  logic                       PRESETn,
  input  logic                       psel,
  input  logic                       penable,
  input  logic                       pwrite,
  input  logic [7:0]                 paddr,
  input  logic [gpio_pkg::XLEN-1:0]  pwdata,
  output logic [gpio_pkg::NREGS-1:0] wr_sel,
  output logic [31:0]                wdata,
  output logic [7:0]                 rd_offset
);

  logic wr_access;

  // word aligned offset, also used for the read mux
  assign rd_offset = {paddr[7:2], 2'b00};

  // write only in the access phase
  assign wr_access = psel & penable & pwrite;

  // pick the 32-bit lane on a wide bus
  if (gpio_pkg::XLEN == 64) begin : g_wide
    assign wdata = paddr[2] ? pwdata[63:32] : pwdata[31:0];
  end else begin : g_narrow
    assign wdata = pwdata[31:0];
  end

  always_comb begin
    wr_sel = '0;
    if (wr_access) begin
      case (rd_offset)
        gpio_pkg::ADDR_INPUT_EN:   wr_sel[gpio_pkg::REG_INPUT_EN]   = 1'b1;
        gpio_pkg::ADDR_OUTPUT_EN:  wr_sel[gpio_pkg::REG_OUTPUT_EN]  = 1'b1;
        gpio_pkg::ADDR_OUTPUT_VAL: wr_sel[gpio_pkg::REG_OUTPUT_VAL] = 1'b1;
        gpio_pkg::ADDR_RISE_IE:    wr_sel[gpio_pkg::REG_RISE_IE]    = 1'b1;
        gpio_pkg::ADDR_RISE_IP:    wr_sel[gpio_pkg::REG_RISE_IP]    = 1'b1;
        gpio_pkg::ADDR_FALL_IE:    wr_sel[gpio_pkg::REG_FALL_IE]    = 1'b1;
        gpio_pkg::ADDR_FALL_IP:    wr_sel[gpio_pkg::REG_FALL_IP]    = 1'b1;
        gpio_pkg::ADDR_HIGH_IE:    wr_sel[gpio_pkg::REG_HIGH_IE]    = 1'b1;
        gpio_pkg::ADDR_HIGH_IP:    wr_sel[gpio_pkg::REG_HIGH_IP]    = 1'b1;
        gpio_pkg::ADDR_LOW_IE:     wr_sel[gpio_pkg::REG_LOW_IE]     = 1'b1;
        gpio_pkg::ADDR_LOW_IP:     wr_sel[gpio_pkg::REG_LOW_IP]     = 1'b1;
        gpio_pkg::ADDR_IOF_EN:     wr_sel[gpio_pkg::REG_IOF_EN]     = 1'b1;
        gpio_pkg::ADDR_IOF_SEL:    wr_sel[gpio_pkg::REG_IOF_SEL]    = 1'b1;
        gpio_pkg::ADDR_OUT_XOR:    wr_sel[gpio_pkg::REG_OUT_XOR]    = 1'b1;
        // INPUT_VAL and holes in the map take no write
        default:                   wr_sel = '0;
      endcase
    end
  end

  // a write selects one register for a single cycle
  a_wr_sel_onehot: assert property (@(posedge PCLK) disable iff (!PRESETn)
    (|wr_sel) |-> $onehot(wr_sel) ##1 (wr_sel == '0));

  // an access phase always follows a setup phase
  a_setup_first: assert property (@(posedge PCLK) disable iff (!PRESETn)
    (psel && penable) |-> $past(psel && !penable));

endmodule

`default_nettype wire

//--- hw/gpio_regs.sv
//////////////////////////////////////////////////////////////////////
// GPIO control registers and pending-bit state
// pending bits are write-one-to-clear; a clear beats a set that edge
// pins with input_en low read zero and never raise pending bits
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module gpio_regs (
  input  logic                       PCLK,
  input  logic                       PRESETn,
  input  logic [gpio_pkg::NREGS-1:0] wr_sel,
  input  logic [31:0]                wdata,
  input  logic [gpio_pkg::NPINS-1:0] pins_in,
  input  logic [gpio_pkg::NPINS-1:0] pin_out,
  output logic [gpio_pkg::NPINS-1:0] input_val,
  output logic [gpio_pkg::NPINS-1:0] input_en,
  output logic [gpio_pkg::NPINS-1:0] output_en,
  output logic [gpio_pkg::NPINS-1:0] output_val,
  output logic [gpio_pkg::NPINS-1:0] rise_ie,
  output logic [gpio_pkg::NPINS-1:0] rise_ip,
  output logic [gpio_pkg::NPINS-1:0] fall_ie,
  output logic [gpio_pkg::NPINS-1:0] fall_ip,
  output logic [gpio_pkg::NPINS-1:0] high_ie,
  output logic [gpio_pkg::NPINS-1:0] high_ip,
  output logic [gpio_pkg::NPINS-1:0] low_ie,
  output logic [gpio_pkg::NPINS-1:0] low_ip,
  output logic [gpio_pkg::NPINS-1:0] iof_en,
  output logic [gpio_pkg::NPINS-1:0] iof_sel,
  output logic [gpio_pkg::NPINS-1:0] out_xor
);

  logic [gpio_pkg::NPINS-1:0] sync_d;
  logic [gpio_pkg::NPINS-1:0] sync_q;
  logic [gpio_pkg::NPINS-1:0] sync_prev;
  logic [gpio_pkg::NPINS-1:0] rise_set, fall_set, high_set, low_set;

  //////////////////////////////////////////////////////////////////////
  // input path
  //////////////////////////////////////////////////////////////////////

  // loopback drives enabled outputs onto their own inputs
  if (gpio_pkg::LOOPBACK) begin : g_loop
    assign sync_d = ((output_en & pin_out) | (~output_en & pins_in)) & input_en;
  end else begin : g_pins
    assign sync_d = pins_in & input_en;
  end

  gpio_sync #(
    .STAGES (gpio_pkg::SYNC_STAGES)
  ) u_sync (
    .PCLK    (PCLK),
    .PRESETn (PRESETn),
    .d       (sync_d),
    .q       (sync_q),
    .q_prev  (sync_prev)
  );

  assign input_val = sync_q;

  // edges seen between the last two stages land with the new level
  assign rise_set = sync_prev & ~sync_q;
  assign fall_set = ~sync_prev & sync_q;
  assign high_set = sync_q;
  // disabled pins sit at zero, so low needs the enable as well
  assign low_set  = ~sync_q & input_en;

  //////////////////////////////////////////////////////////////////////
  // register file
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge PCLK or negedge PRESETn) begin
    if (!PRESETn) begin
      input_en   <= '0;
      output_en  <= '0;
      output_val <= '0;
      rise_ie    <= '0;
      fall_ie    <= '0;
      high_ie    <= '0;
      low_ie     <= '0;
      iof_en     <= '0;
      iof_sel    <= '0;
      out_xor    <= '0;
      rise_ip    <= '0;
      fall_ip    <= '0;
      high_ip    <= '0;
      low_ip     <= '0;
    end else begin
      // plain control registers
      if (wr_sel[gpio_pkg::REG_INPUT_EN])   input_en   <= wdata;
      if (wr_sel[gpio_pkg::REG_OUTPUT_EN])  output_en  <= wdata;
      if (wr_sel[gpio_pkg::REG_OUTPUT_VAL]) output_val <= wdata;
      if (wr_sel[gpio_pkg::REG_RISE_IE])    rise_ie    <= wdata;
      if (wr_sel[gpio_pkg::REG_FALL_IE])    fall_ie    <= wdata;
      if (wr_sel[gpio_pkg::REG_HIGH_IE])    high_ie    <= wdata;
      if (wr_sel[gpio_pkg::REG_LOW_IE])     low_ie     <= wdata;
      if (wr_sel[gpio_pkg::REG_IOF_EN])     iof_en     <= wdata;
      if (wr_sel[gpio_pkg::REG_IOF_SEL])    iof_sel    <= wdata;
      if (wr_sel[gpio_pkg::REG_OUT_XOR])    out_xor    <= wdata;

      // pending bits, sticky until written with ones
      if (wr_sel[gpio_pkg::REG_RISE_IP]) rise_ip <= rise_ip & ~wdata;
      else                               rise_ip <= rise_ip | rise_set;
      if (wr_sel[gpio_pkg::REG_FALL_IP]) fall_ip <= fall_ip & ~wdata;
      else                               fall_ip <= fall_ip | fall_set;
      if (wr_sel[gpio_pkg::REG_HIGH_IP]) high_ip <= high_ip & ~wdata;
      else                               high_ip <= high_ip | high_set;
      if (wr_sel[gpio_pkg::REG_LOW_IP])  low_ip  <= low_ip & ~wdata;
      else                               low_ip  <= low_ip | low_set;
    end
  end

  // a new pending bit needs the matching input_val history
  // edges show up together with the new level, levels one edge later
  a_pend_cause: assert property (@(posedge PCLK) disable iff (!PRESETn)
    ((rise_ip & ~$past(rise_ip) & ~(input_val & ~$past(input_val))) |
     (fall_ip & ~$past(fall_ip) & ~(~input_val & $past(input_val))) |
     (high_ip & ~$past(high_ip) & ~$past(input_val)) |
     (low_ip & ~$past(low_ip) & ~$past(~input_val & input_en))) == '0);

endmodule

`default_nettype wire

//--- hw/gpio_result.sv
//////////////////////////////////////////////////////////////////////
// read data, pin drive and interrupt for the GPIO block
// prdata is a flop, loaded every cycle from the current offset
// pins_out, pins_en and irq are purely combinational
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module gpio_result (
  input  logic                       PCLK,
  input  logic                       PRESETn,
  input  logic [7:0]                 rd_offset,
  input  logic [gpio_pkg::NPINS-1:0] input_val,
  input  logic [gpio_pkg::NPINS-1:0] input_en,
  input  logic [gpio_pkg::NPINS-1:0] output_en,
  input  logic [gpio_pkg::NPINS-1:0] output_val,
  input  logic [gpio_pkg::NPINS-1:0] rise_ie,
  input  logic [gpio_pkg::NPINS-1:0] rise_ip,
  input  logic [gpio_pkg::NPINS-1:0] fall_ie,
  input  logic [gpio_pkg::NPINS-1:0] fall_ip,
  input  logic [gpio_pkg::NPINS-1:0] high_ie,
  input  logic [gpio_pkg::NPINS-1:0] high_ip,
  input  logic [gpio_pkg::NPINS-1:0] low_ie,
  input  logic [gpio_pkg::NPINS-1:0] low_ip,
  input  logic [gpio_pkg::NPINS-1:0] iof_en,
  input  logic [gpio_pkg::NPINS-1:0] iof_sel,
  input  logic [gpio_pkg::NPINS-1:0] out_xor,
  input  logic [gpio_pkg::NPINS-1:0] iof0,
  input  logic [gpio_pkg::NPINS-1:0] iof1,
  output logic [gpio_pkg::XLEN-1:0]  prdata,
  output logic [gpio_pkg::NPINS-1:0] pins_out,
  output logic [gpio_pkg::NPINS-1:0] pins_en,
  output logic                       irq
);

  logic [31:0]                rd_word;
  logic [gpio_pkg::XLEN-1:0]  rd_bus;
  logic [gpio_pkg::NPINS-1:0] iof_out;
  logic [gpio_pkg::NPINS-1:0] pin_val;

  //////////////////////////////////////////////////////////////////////
  // read path
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    case (rd_offset)
      gpio_pkg::ADDR_INPUT_VAL:  rd_word = input_val;
      gpio_pkg::ADDR_INPUT_EN:   rd_word = input_en;
      gpio_pkg::ADDR_OUTPUT_EN:  rd_word = output_en;
      gpio_pkg::ADDR_OUTPUT_VAL: rd_word = output_val;
      gpio_pkg::ADDR_RISE_IE:    rd_word = rise_ie;
      gpio_pkg::ADDR_RISE_IP:    rd_word = rise_ip;
      gpio_pkg::ADDR_FALL_IE:    rd_word = fall_ie;
      gpio_pkg::ADDR_FALL_IP:    rd_word = fall_ip;
      gpio_pkg::ADDR_HIGH_IE:    rd_word = high_ie;
      gpio_pkg::ADDR_HIGH_IP:    rd_word = high_ip;
      gpio_pkg::ADDR_LOW_IE:     rd_word = low_ie;
      gpio_pkg::ADDR_LOW_IP:     rd_word = low_ip;
      gpio_pkg::ADDR_IOF_EN:     rd_word = iof_en;
      gpio_pkg::ADDR_IOF_SEL:    rd_word = iof_sel;
      gpio_pkg::ADDR_OUT_XOR:    rd_word = out_xor;
      // unmapped offsets read zero
      default:                   rd_word = '0;
    endcase
  end

  // word goes to the lane named by address bit 2 on a wide bus
  if (gpio_pkg::XLEN == 64) begin : g_wide
    assign rd_bus = rd_offset[2] ? {rd_word, 32'b0} : {32'b0, rd_word};
  end else begin : g_narrow
    assign rd_bus = rd_word;
  end

  // setup-phase address gives data held through the access phase
  always_ff @(posedge PCLK or negedge PRESETn) begin
    if (!PRESETn) begin
      prdata <= '0;
    end else begin
      prdata <= rd_bus;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // pin drive and interrupt
  //////////////////////////////////////////////////////////////////////
  // per pin: iof1 over iof0, then IOF over output_val, then polarity
  assign iof_out  = (iof_sel & iof1) | (~iof_sel & iof0);
  assign pin_val  = (iof_en & iof_out) | (~iof_en & output_val);
  assign pins_out = pin_val ^ out_xor;
  assign pins_en  = output_en;

  assign irq = |{rise_ip & rise_ie, fall_ip & fall_ie,
                 high_ip & high_ie, low_ip & low_ie};

endmodule

`default_nettype wire

//--- hw/gpio_apb.sv
//////////////////////////////////////////////////////////////////////
// 32-pin GPIO with an APB slave port
// PREADY is always high, no error response; PSTRB is ignored
// so every write updates the full 32-bit register
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module gpio_apb (
  input  logic                        PCLK,
  input  logic                        PRESETn,
  input  logic                        PSEL,
  input  logic                        PENABLE,
  input  logic                        PWRITE,
  input  logic [7:0]                  PADDR,
  input  logic [gpio_pkg::XLEN-1:0]   PWDATA,
  input  logic [gpio_pkg::XLEN/8-1:0] PSTRB,
  input  logic [gpio_pkg::NPINS-1:0]  iof0,
  input  logic [gpio_pkg::NPINS-1:0]  iof1,
  input  logic [gpio_pkg::NPINS-1:0]  pins_in,
  output logic [gpio_pkg::XLEN-1:0]   PRDATA,
  output logic                        PREADY,
  output logic [gpio_pkg::NPINS-1:0]  pins_out,
  output logic [gpio_pkg::NPINS-1:0]  pins_en,
  output logic                        irq
);

  logic [gpio_pkg::NREGS-1:0] wr_sel;
  logic [31:0]                wdata;
  logic [7:0]                 rd_offset;
  logic [gpio_pkg::NPINS-1:0] input_val, input_en, output_en, output_val;
  logic [gpio_pkg::NPINS-1:0] rise_ie, rise_ip, fall_ie, fall_ip;
  logic [gpio_pkg::NPINS-1:0] high_ie, high_ip, low_ie, low_ip;
  logic [gpio_pkg::NPINS-1:0] iof_en, iof_sel, out_xor;

  // single cycle access phase, slave never stalls
  assign PREADY = 1'b1;

  gpio_apb_decode u_decode (
    .PCLK (PCLK), .PRESETn (PRESETn),
    .psel (PSEL), .penable (PENABLE), .pwrite (PWRITE),
    .paddr (PADDR), .pwdata (PWDATA),
    .wr_sel (wr_sel), .wdata (wdata), .rd_offset (rd_offset)
  );

  // pins_out returns to the register stage for loopback
  gpio_regs u_regs (
    .PCLK (PCLK), .PRESETn (PRESETn),
    .wr_sel (wr_sel), .wdata (wdata), .pins_in (pins_in), .pin_out (pins_out),
    .input_val (input_val), .input_en (input_en),
    .output_en (output_en), .output_val (output_val),
    .rise_ie (rise_ie), .rise_ip (rise_ip), .fall_ie (fall_ie), .fall_ip (fall_ip),
    .high_ie (high_ie), .high_ip (high_ip), .low_ie (low_ie), .low_ip (low_ip),
    .iof_en (iof_en), .iof_sel (iof_sel), .out_xor (out_xor)
  );

  gpio_result u_result (
    .PCLK (PCLK), .PRESETn (PRESETn), .rd_offset (rd_offset),
    .input_val (input_val), .input_en (input_en),
    .output_en (output_en), .output_val (output_val),
    .rise_ie (rise_ie), .rise_ip (rise_ip), .fall_ie (fall_ie), .fall_ip (fall_ip),
    .high_ie (high_ie), .high_ip (high_ip), .low_ie (low_ie), .low_ip (low_ip),
    .iof_en (iof_en), .iof_sel (iof_sel), .out_xor (out_xor),
    .iof0 (iof0), .iof1 (iof1),
    .prdata (PRDATA), .pins_out (pins_out), .pins_en (pins_en), .irq (irq)
  );

endmodule

`default_nettype wire

//--- bench/tb_clkgen.sv
//////////////////////////////////////////////////////////////////////
// free-running 4 ns clock for the GPIO testbench
// reset is held low for the first 8 rising edges
// and released on a falling edge, away from the sampling edge
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_clkgen (
  output logic PCLK,
  output logic PRESETn
);

  // 2 ns half period
  initial begin
    PCLK = 1'b0;
    forever #2 PCLK = ~PCLK;
  end

  initial begin
    PRESETn = 1'b0;
    repeat (8) @(posedge PCLK);
    @(negedge PCLK);
    PRESETn = 1'b1;
  end

endmodule

`default_nettype wire

//--- bench/tb_gpio_ref.svh
//////////////////////////////////////////////////////////////////////
// reference model functions for the GPIO testbench
// included inside the testbench module, which must declare shadow[]
// register words are 32 bits, offsets are word aligned
//////////////////////////////////////////////////////////////////////

`ifndef TB_GPIO_REF_SVH
`define TB_GPIO_REF_SVH

// shadow array slot of a register offset
function automatic int widx(input logic [7:0] offset);
  return offset >> 2;
endfunction

// offsets 0x00 to 0x40 are mapped, except the hole at 0x10 and 0x14
function automatic bit is_mapped(input logic [7:0] offset);
  return (offset <= gpio_pkg::ADDR_OUT_XOR) && (offset != 8'h10) && (offset != 8'h14);
endfunction

// write-one-to-clear registers
function automatic bit is_pending(input logic [7:0] offset);
  return offset inside {gpio_pkg::ADDR_RISE_IP, gpio_pkg::ADDR_FALL_IP,
                        gpio_pkg::ADDR_HIGH_IP, gpio_pkg::ADDR_LOW_IP};
endfunction

// expected read-back, unmapped offsets give zero
function automatic logic [31:0] exp_readback(input logic [7:0] offset);
  return is_mapped(offset) ? shadow[widx(offset)] : 32'h0;
endfunction

// pin drive, one pin at a time
function automatic logic [31:0] exp_pins(input logic [31:0] oval, ien, isel, oxor, i0, i1);
  logic [31:0] r;
  for (int p = 0; p < gpio_pkg::NPINS; p++) begin
    if (ien[p]) r[p] = isel[p] ? i1[p] : i0[p];
    else        r[p] = oval[p];
    r[p] = r[p] ^ oxor[p];
  end
  return r;
endfunction

// level seen by the synchronizer, with the loopback mix when enabled
function automatic logic [31:0] in_seen(input logic [31:0] pins, en, oen, pout);
  logic [31:0] src;
  src = gpio_pkg::LOOPBACK ? ((pout & oen) | (pins & ~oen)) : pins;
  return src & en;
endfunction

// edges between two settled input levels
function automatic logic [31:0] rise_bits(input logic [31:0] old_v, new_v);
  return new_v & ~old_v;
endfunction

function automatic logic [31:0] fall_bits(input logic [31:0] old_v, new_v);
  return old_v & ~new_v;
endfunction

// low level only counts on enabled pins
function automatic logic [31:0] low_bits(input logic [31:0] v, en);
  return en & ~v;
endfunction

// interrupt line from pending bits and enables
function automatic bit irq_ref(input logic [31:0] rp, re, fp, fe, hp, he, lp, le);
  for (int p = 0; p < gpio_pkg::NPINS; p++) begin
    if ((rp[p] && re[p]) || (fp[p] && fe[p]) || (hp[p] && he[p]) || (lp[p] && le[p]))
      return 1'b1;
  end
  return 1'b0;
endfunction

`endif

//--- bench/tb_gpio.sv
//////////////////////////////////////////////////////////////////////
// testbench for the APB GPIO block, run with XLEN 32
// covers reset, read-back, pin drive, input sampling, pending, irq
// stimulus is random from a fixed seed; LOOPBACK is followed if set
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_gpio;

  // test lengths
  localparam int XFER    = 3;
  localparam int HOLD    = 4;
  localparam int ROUNDS  = 3;
  localparam int N_OUT   = 12;
  localparam int N_IN    = 10;
  localparam int N_EDGE  = 8;
  localparam int N_LEVEL = 8;
  // cycle budget per test, the timeout is twice the sum
  localparam int RESET_CYC = 8 + 17 * XFER + 6;
  localparam int REGS_CYC  = ROUNDS * 35 * XFER;
  localparam int OUT_CYC   = N_OUT * 6 * (XFER + 1);
  localparam int IN_CYC    = N_IN * (2 * XFER + HOLD + 1);
  localparam int EDGE_CYC  = N_EDGE * (17 * XFER + 3 * HOLD + 8);
  localparam int LEVEL_CYC = 2 * XFER + N_LEVEL * (7 * XFER + 2 * HOLD + 4);
  localparam int LIMIT = 2 * (RESET_CYC + REGS_CYC + OUT_CYC + IN_CYC + EDGE_CYC + LEVEL_CYC);

  logic                         PCLK, PRESETn;
  logic                         psel, penable, pwrite, pready, irq;
  logic [7:0]                   paddr;
  logic [gpio_pkg::XLEN-1:0]    pwdata, prdata;
  logic [gpio_pkg::XLEN/8-1:0]  pstrb;
  logic [gpio_pkg::NPINS-1:0]   iof0, iof1, pins_in, pins_out, pins_en;

  // register copies kept by the testbench, one slot per word offset
  logic [31:0] shadow [0:16];

  // checks waiting for the comparing process
  string       name_q [$];
  logic [31:0] exp_q [$];
  logic [31:0] act_q [$];
  string       chk_name;
  logic [31:0] chk_exp, chk_act;

  int n_checks    = 0;
  int n_val_err   = 0;
  int n_other_err = 0;
  int cycles      = 0;

`include "tb_gpio_ref.svh"

  tb_clkgen u_clk (
    .PCLK    (PCLK),
    .PRESETn (PRESETn)
  );

  gpio_apb dut (
    .PCLK (PCLK), .PRESETn (PRESETn),
    .PSEL (psel), .PENABLE (penable), .PWRITE (pwrite),
    .PADDR (paddr), .PWDATA (pwdata), .PSTRB (pstrb),
    .iof0 (iof0), .iof1 (iof1), .pins_in (pins_in),
    .PRDATA (prdata), .PREADY (pready),
    .pins_out (pins_out), .pins_en (pins_en), .irq (irq)
  );

  //////////////////////////////////////////////////////////////////////
  // bus and check helpers
  //////////////////////////////////////////////////////////////////////
  task automatic queue_check(input string name, input logic [31:0] exp, act);
    name_q.push_back(name);
    exp_q.push_back(exp);
    act_q.push_back(act);
  endtask

  // setup phase, access phase, then the write lands on the closing edge
  task automatic bus_transfer(input bit wr, input logic [7:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata);
    int waited;
    waited = 0;
    @(posedge PCLK);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= addr;
    pwdata  <= {(gpio_pkg::XLEN / 32){wdata}};
    pstrb   <= {(gpio_pkg::XLEN / 8){wr}};
    @(posedge PCLK);
    penable <= 1'b1;
    @(negedge PCLK);
    while (!pready && waited < 16) begin
      @(negedge PCLK);
      waited++;
    end
    assert (pready) else begin
      $display("APB transfer at offset %02h did not complete, PREADY stayed low", addr);
      n_other_err++;
    end
    // read data came from the setup-phase address
    rdata = 32'(prdata >> (addr[2] ? gpio_pkg::XLEN - 32 : 0));
    @(posedge PCLK);
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    if (wr && is_mapped(addr) && addr != gpio_pkg::ADDR_INPUT_VAL) begin
      if (is_pending(addr)) shadow[widx(addr)] = shadow[widx(addr)] & ~wdata;
      else                  shadow[widx(addr)] = wdata;
    end
  endtask

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
    logic [31:0] unused;
    bus_transfer(1'b1, addr, data, unused);
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
    bus_transfer(1'b0, addr, 32'h0, data);
  endtask

  task automatic read_and_compare(input string name, input logic [7:0] addr,
                                  input logic [31:0] exp);
    logic [31:0] got;
    apb_read(addr, got);
    queue_check(name, exp, got);
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge PCLK);
  endtask

  task automatic hold_pins(input logic [31:0] value);
    @(posedge PCLK);
    pins_in <= value;
  endtask

  task automatic expect_irq(input string name, input bit exp);
    @(negedge PCLK);
    queue_check(name, 32'(exp), 32'(irq));
  endtask

  // pins are combinational, so look half a cycle after the edge
  task automatic check_pins(input string name);
    @(negedge PCLK);
    queue_check({name, " pins_out"},
                exp_pins(shadow[widx(gpio_pkg::ADDR_OUTPUT_VAL)],
                         shadow[widx(gpio_pkg::ADDR_IOF_EN)],
                         shadow[widx(gpio_pkg::ADDR_IOF_SEL)],
                         shadow[widx(gpio_pkg::ADDR_OUT_XOR)], iof0, iof1), pins_out);
    queue_check({name, " pins_en"}, shadow[widx(gpio_pkg::ADDR_OUTPUT_EN)], pins_en);
  endtask

  task automatic write_and_probe(input logic [7:0] offset);
    apb_write(offset, $urandom());
    check_pins($sformatf("write %02h", offset));
  endtask

  //////////////////////////////////////////////////////////////////////
  // comparing process and timeout
  //////////////////////////////////////////////////////////////////////
  always @(negedge PCLK) begin
    while (act_q.size() > 0) begin
      chk_name = name_q.pop_front();
      chk_exp  = exp_q.pop_front();
      chk_act  = act_q.pop_front();
      n_checks++;
      assert (chk_act === chk_exp) else begin
        $display("FAIL %s expected %h actual %h", chk_name, chk_exp, chk_act);
        n_val_err++;
      end
    end
  end

  always @(posedge PCLK) begin
    cycles++;
    if (cycles >= LIMIT) begin
      $display("timeout after %0d cycles, the tests did not finish", cycles);
      $display("TEST FAILED");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////
  initial begin
    logic [31:0] rd, en, pat, eff, prev_eff, drop, clr, oen, drv;
    logic [31:0] exp_r, exp_f, ie_r, ie_f, ie_h, ie_l;
    int seed;
    seed = 55;
    rd = $urandom(seed);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    pstrb   = '0;
    iof0    = '0;
    iof1    = '0;
    pins_in = '0;
    for (int i = 0; i <= 16; i++) shadow[i] = 32'h0;
    wait (PRESETn === 1'b1);
    @(negedge PCLK);

    // reset state, including the hole at 0x10 and 0x14
    assert (irq === 1'b0) else begin
      $display("irq is not low after reset");
      n_other_err++;
    end
    queue_check("reset pins_en", 32'h0, pins_en);
    for (int a = 0; a < 8'h44; a += 4) read_and_compare($sformatf("reset %02h", a), 8'(a), 0);

    // write and read back, input enable last so pending stays quiet
    for (int r = 0; r < ROUNDS; r++) begin
      for (int a = 4; a <= 8'h40; a += 4) begin
        if (is_mapped(8'(a)) && a != gpio_pkg::ADDR_INPUT_EN) begin
          apb_write(8'(a), $urandom());
          read_and_compare($sformatf("readback %02h", a), 8'(a), exp_readback(8'(a)));
        end
      end
      apb_write(gpio_pkg::ADDR_INPUT_EN, $urandom());
      read_and_compare("readback input_en", gpio_pkg::ADDR_INPUT_EN,
                       exp_readback(gpio_pkg::ADDR_INPUT_EN));
      apb_write(gpio_pkg::ADDR_INPUT_EN, 32'h0);
      read_and_compare("input_en back to zero", gpio_pkg::ADDR_INPUT_EN, 32'h0);
      rd = 8'h44 + 4 * ($urandom() % 47);
      read_and_compare($sformatf("unmapped %02h", rd[7:0]), rd[7:0], 32'h0);
      // low pending filled up while inputs were enabled
      apb_write(gpio_pkg::ADDR_RISE_IP, '1);
      apb_write(gpio_pkg::ADDR_FALL_IP, '1);
      apb_write(gpio_pkg::ADDR_HIGH_IP, '1);
      apb_write(gpio_pkg::ADDR_LOW_IP, '1);
    end

    // output composition
    for (int i = 0; i < N_OUT; i++) begin
      @(posedge PCLK);
      iof0 <= $urandom();
      iof1 <= $urandom();
      check_pins("iof change");
      write_and_probe(gpio_pkg::ADDR_OUTPUT_VAL);
      write_and_probe(gpio_pkg::ADDR_OUTPUT_EN);
      write_and_probe(gpio_pkg::ADDR_IOF_EN);
      write_and_probe(gpio_pkg::ADDR_IOF_SEL);
      write_and_probe(gpio_pkg::ADDR_OUT_XOR);
    end
    // output side stays fixed from here on, for the loopback model
    oen = shadow[widx(gpio_pkg::ADDR_OUTPUT_EN)];
    drv = exp_pins(shadow[widx(gpio_pkg::ADDR_OUTPUT_VAL)],
                   shadow[widx(gpio_pkg::ADDR_IOF_EN)],
                   shadow[widx(gpio_pkg::ADDR_IOF_SEL)],
                   shadow[widx(gpio_pkg::ADDR_OUT_XOR)], iof0, iof1);

    // input sampling
    for (int i = 0; i < N_IN; i++) begin
      en  = $urandom();
      pat = $urandom();
      apb_write(gpio_pkg::ADDR_INPUT_EN, en);
      hold_pins(pat);
      wait_cycles(HOLD);
      apb_read(gpio_pkg::ADDR_INPUT_VAL, rd);
      queue_check("input_val", in_seen(pat, en, oen, drv), rd);
      queue_check("input_val outside mask", 32'h0, rd & ~en);
    end

    // edge pending and interrupt
    for (int i = 0; i < N_EDGE; i++) begin
      en   = $urandom();
      ie_r = $urandom();
      ie_f = $urandom();
      hold_pins(32'h0);
      apb_write(gpio_pkg::ADDR_INPUT_EN, en);
      apb_write(gpio_pkg::ADDR_RISE_IE, ie_r);
      apb_write(gpio_pkg::ADDR_FALL_IE, ie_f);
      apb_write(gpio_pkg::ADDR_HIGH_IE, 32'h0);
      apb_write(gpio_pkg::ADDR_LOW_IE, 32'h0);
      wait_cycles(HOLD);
      apb_write(gpio_pkg::ADDR_RISE_IP, '1);
      apb_write(gpio_pkg::ADDR_FALL_IP, '1);
      prev_eff = in_seen(32'h0, en, oen, drv);
      pat = $urandom();
      hold_pins(pat);
      wait_cycles(HOLD);
      eff   = in_seen(pat, en, oen, drv);
      exp_r = rise_bits(prev_eff, eff);
      exp_f = fall_bits(prev_eff, eff);
      read_and_compare("rise_ip after rise", gpio_pkg::ADDR_RISE_IP, exp_r);
      read_and_compare("fall_ip after rise", gpio_pkg::ADDR_FALL_IP, exp_f);
      expect_irq("irq after rise", irq_ref(exp_r, ie_r, exp_f, ie_f, '0, '0, '0, '0));
      // drop some of the high pins
      drop     = $urandom();
      prev_eff = eff;
      hold_pins(pat & ~drop);
      wait_cycles(HOLD);
      eff   = in_seen(pat & ~drop, en, oen, drv);
      exp_r = exp_r | rise_bits(prev_eff, eff);
      exp_f = exp_f | fall_bits(prev_eff, eff);
      read_and_compare("rise_ip after fall", gpio_pkg::ADDR_RISE_IP, exp_r);
      read_and_compare("fall_ip after fall", gpio_pkg::ADDR_FALL_IP, exp_f);
      expect_irq("irq after fall", irq_ref(exp_r, ie_r, exp_f, ie_f, '0, '0, '0, '0));
      // partial clear must leave the other bits alone
      clr = $urandom();
      apb_write(gpio_pkg::ADDR_RISE_IP, clr);
      exp_r = exp_r & ~clr;
      read_and_compare("rise_ip partial clear", gpio_pkg::ADDR_RISE_IP, exp_r);
      expect_irq("irq partial clear", irq_ref(exp_r, ie_r, exp_f, ie_f, '0, '0, '0, '0));
      apb_write(gpio_pkg::ADDR_RISE_IP, '1);
      apb_write(gpio_pkg::ADDR_FALL_IP, '1);
      read_and_compare("rise_ip cleared", gpio_pkg::ADDR_RISE_IP, 32'h0);
      read_and_compare("fall_ip cleared", gpio_pkg::ADDR_FALL_IP, 32'h0);
      expect_irq("irq after clear", 1'b0);
    end

    // level pending, edges masked off from here on
    apb_write(gpio_pkg::ADDR_RISE_IE, 32'h0);
    apb_write(gpio_pkg::ADDR_FALL_IE, 32'h0);
    for (int i = 0; i < N_LEVEL; i++) begin
      en   = $urandom();
      pat  = $urandom();
      ie_h = $urandom();
      ie_l = $urandom();
      apb_write(gpio_pkg::ADDR_INPUT_EN, en);
      apb_write(gpio_pkg::ADDR_HIGH_IE, ie_h);
      apb_write(gpio_pkg::ADDR_LOW_IE, ie_l);
      hold_pins(pat);
      wait_cycles(HOLD);
      apb_write(gpio_pkg::ADDR_HIGH_IP, '1);
      apb_write(gpio_pkg::ADDR_LOW_IP, '1);
      wait_cycles(HOLD);
      eff = in_seen(pat, en, oen, drv);
      read_and_compare("high_ip level", gpio_pkg::ADDR_HIGH_IP, eff);
      read_and_compare("low_ip level", gpio_pkg::ADDR_LOW_IP, low_bits(eff, en));
      expect_irq("irq level",
                 irq_ref('0, '0, '0, '0, eff, ie_h, low_bits(eff, en), ie_l));
    end

    // Let the comparing process drain its queue.
    repeat (2) @(negedge PCLK);
    $display("checks %0d, value errors %0d, other errors %0d",
             n_checks, n_val_err, n_other_err);
    if (n_val_err == 0 && n_other_err == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+bench
hw/gpio_pkg.sv
hw/gpio_sync.sv
hw/gpio_apb_decode.sv
hw/gpio_regs.sv
hw/gpio_result.sv
hw/gpio_apb.sv
bench/tb_clkgen.sv
bench/tb_gpio.sv
